// File: include/font_8x8.svh
`ifndef FONT_8X8_SVH
`define FONT_8X8_SVH

// one entry per glyph code, rows listed top first (row 7 down to row 0)
// bit 7 of each row is the leftmost pixel
localparam logic [7:0] FONT_ROWS [0:GLYPH_CODES-1][7:0] = '{
    '{8'b00111100,  // 0
      8'b01000010,
      8'b01000110,
      8'b01001010,
      8'b01010010,
      8'b01100010,
      8'b01000010,
      8'b00111100},
    '{8'b00011000,  // 1
      8'b00101000,
      8'b01001000,
      8'b00001000,
      8'b00001000,
      8'b00001000,
      8'b00001000,
      8'b01111110},
    '{8'b00111100,  // 2
      8'b01000010,
      8'b00000010,
      8'b00000100,
      8'b00001000,
      8'b00010000,
      8'b00100000,
      8'b01111110},
    '{8'b00111100,  // 3
      8'b01000010,
      8'b00000010,
      8'b00011100,
      8'b00000010,
      8'b00000010,
      8'b01000010,
      8'b00111100},
    '{8'b00000100,  // 4
      8'b00001100,
      8'b00010100,
      8'b00100100,
      8'b01000100,
      8'b01111110,
      8'b00000100,
      8'b00000100},
    '{8'b01111110,  // 5
      8'b01000000,
      8'b01000000,
      8'b01111100,
      8'b00000010,
      8'b00000010,
      8'b01000010,
      8'b00111100},
    '{8'b00111100,  // 6
      8'b01000000,
      8'b01000000,
      8'b01111100,
      8'b01000010,
      8'b01000010,
      8'b01000010,
      8'b00111100},
    '{8'b01111110,  // 7
      8'b00000010,
      8'b00000100,
      8'b00001000,
      8'b00010000,
      8'b00010000,
      8'b00010000,
      8'b00010000},
    '{8'b00111100,  // 8
      8'b01000010,
      8'b01000010,
      8'b00111100,
      8'b01000010,
      8'b01000010,
      8'b01000010,
      8'b00111100},
    '{8'b00111100,  // 9
      8'b01000010,
      8'b01000010,
      8'b00111110,
      8'b00000010,
      8'b00000010,
      8'b00000010,
      8'b00111100},
    '{8'b00000000,  // minus
      8'b00000000,
      8'b00000000,
      8'b00000000,
      8'b01111110,  // bar sits on row 3
      8'b00000000,
      8'b00000000,
      8'b00000000},
    '{8'b00000000,  // blank
      8'b00000000,
      8'b00000000,
      8'b00000000,
      8'b00000000,
      8'b00000000,
      8'b00000000,
      8'b00000000}
};

`endif

// File: logic/overlay_cfg_pkg.sv
package overlay_cfg_pkg;

    // glyph cell is square
    localparam int FONT_W = 8;

    // RGB444
    localparam int PIXEL_W = 12;

    typedef logic [PIXEL_W-1:0] pixel_t;

    // raster coordinates, up to 2047
    localparam int COORD_W = 11;

    typedef logic [COORD_W-1:0] coord_t;

    localparam pixel_t FG_PIXEL = '0;  // black ink
    localparam pixel_t BG_PIXEL = '1;  // white paper

endpackage

// File: logic/glyph_pkg.sv
package glyph_pkg;

    // digit glyphs carry their own value so a BCD nibble casts straight in
    typedef enum logic [3:0] {
        GLYPH_0     = 4'd0,
        GLYPH_1     = 4'd1,
        GLYPH_2     = 4'd2,
        GLYPH_3     = 4'd3,
        GLYPH_4     = 4'd4,
        GLYPH_5     = 4'd5,
        GLYPH_6     = 4'd6,
        GLYPH_7     = 4'd7,
        GLYPH_8     = 4'd8,
        GLYPH_9     = 4'd9,
        GLYPH_MINUS = 4'd10,
        GLYPH_BLANK = 4'd11
    } glyph_e;

    typedef enum logic [1:0] {
        CONV_IDLE,
        CONV_SHIFT,   // double-dabble steps
        CONV_WRITE    // one glyph slot per cycle
    } conv_state_e;

    localparam int GLYPH_CODES = 12;  // font table depth

    `include "font_8x8.svh"

endpackage

// File: logic/glyph_wr_if.sv
interface glyph_wr_if import glyph_pkg::*; #(
    parameter int NUM_GLYPHS = 6
);

    logic                          wr_en;
    logic [$clog2(NUM_GLYPHS)-1:0] wr_addr;    // slot 0 is the sign
    glyph_e                        wr_glyph;
    logic                          wr_commit;  // high with the last write

    modport src (
        output wr_en, wr_addr, wr_glyph, wr_commit
    );

    modport dst (
        input wr_en, wr_addr, wr_glyph, wr_commit
    );

endinterface

// File: logic/bcd_converter.sv
module bcd_converter import glyph_pkg::*; #(
    parameter int VALUE_W    = 16,
    parameter int NUM_DIGITS = 5,
    parameter int NUM_GLYPHS = 6
) (
    input  logic               clk,
    input  logic               rst,
    input  logic [VALUE_W-1:0] value,
    input  logic               value_strobe,
    output logic               busy,
    glyph_wr_if.src            wr
);

    localparam int BCD_W   = 4 * NUM_DIGITS;
    localparam int SHIFT_W = $clog2(VALUE_W);
    localparam int SLOT_W  = $clog2(NUM_GLYPHS);

    conv_state_e        state_q;
    logic [SHIFT_W-1:0] shift_cnt_q;
    logic [SLOT_W-1:0]  slot_q;
    logic               sign_q;
    logic [VALUE_W-1:0] mag_q;
    logic [BCD_W-1:0]   bcd_q;
    logic [BCD_W-1:0]   bcd_adj;
    logic               start;
    logic               last_shift;
    logic               last_slot;

    // digits of 5 or more would pass 9 on the next shift
    always_comb begin
        bcd_adj = bcd_q;
        for (int d = 0; d < NUM_DIGITS; d++) begin
            if (bcd_q[d*4 +: 4] >= 4'd5) begin
                bcd_adj[d*4 +: 4] = bcd_q[d*4 +: 4] + 4'd3;
            end
        end
    end

    assign start      = (state_q == CONV_IDLE) && value_strobe;  // strobes while busy drop here
    assign last_shift = (shift_cnt_q == SHIFT_W'(VALUE_W - 1));
    assign last_slot  = (slot_q == SLOT_W'(NUM_GLYPHS - 1));

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q     <= CONV_IDLE;
            shift_cnt_q <= '0;
            slot_q      <= '0;
        end else begin
            case (state_q)
                CONV_IDLE: begin
                    if (value_strobe) begin
                        state_q     <= CONV_SHIFT;
                        shift_cnt_q <= '0;
                        slot_q      <= '0;
                    end
                end
                CONV_SHIFT: begin
                    shift_cnt_q <= shift_cnt_q + 1'b1;
                    if (last_shift) begin
                        state_q <= CONV_WRITE;
                    end
                end
                CONV_WRITE: begin
                    slot_q <= slot_q + 1'b1;
                    if (last_slot) begin
                        state_q <= CONV_IDLE;  // busy drops after the commit cycle
                    end
                end
                default: state_q <= CONV_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            sign_q <= value[VALUE_W-1];
            mag_q  <= value[VALUE_W-1] ? ~value + 1'b1 : value;  // -2^(N-1) still fits unsigned
            bcd_q  <= '0;
        end else if (state_q == CONV_SHIFT) begin
            bcd_q <= {bcd_adj[BCD_W-2:0], mag_q[VALUE_W-1]};
            mag_q <= mag_q << 1;
        end else if (state_q == CONV_WRITE && slot_q != '0) begin
            bcd_q <= bcd_q << 4;  // bring next digit to the top
        end
    end

    assign busy        = (state_q != CONV_IDLE);
    assign wr.wr_en    = (state_q == CONV_WRITE);
    assign wr.wr_addr  = slot_q;
    assign wr.wr_glyph = (slot_q == '0) ? (sign_q ? GLYPH_MINUS : GLYPH_BLANK)
                                        : glyph_e'(bcd_q[BCD_W-1 -: 4]);
    assign wr.wr_commit = wr.wr_en && last_slot;

endmodule

// File: logic/glyph_buffer.sv
module glyph_buffer import glyph_pkg::*; #(
    parameter int NUM_GLYPHS = 6
) (
    input  logic                          clk,
    input  logic                          rst,
    glyph_wr_if.dst                       wr,
    input  logic                          frame_start,
    input  logic [$clog2(NUM_GLYPHS)-1:0] rd_slot,
    output glyph_e                        rd_glyph
);

    glyph_e shadow_q  [NUM_GLYPHS];  // filled by the converter
    glyph_e display_q [NUM_GLYPHS];  // seen by the renderer
    logic   pending_q;
    logic   swap;

    // only swap on a frame edge so a frame never mixes two numbers
    assign swap = frame_start && pending_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < NUM_GLYPHS; i++) begin
                shadow_q[i]  <= GLYPH_BLANK;
                display_q[i] <= GLYPH_BLANK;
            end
            pending_q <= 1'b0;
        end else begin
            if (wr.wr_en) begin
                shadow_q[wr.wr_addr] <= wr.wr_glyph;
            end
            if (swap) begin
                display_q <= shadow_q;
            end
            // a commit landing on the swap cycle waits for the next frame
            pending_q <= wr.wr_commit || (pending_q && !frame_start);
        end
    end

    assign rd_glyph = display_q[rd_slot];  // renderer keeps rd_slot in range

endmodule

// File: logic/glyph_renderer.sv
module glyph_renderer import overlay_cfg_pkg::*, glyph_pkg::*; #(
    parameter int NUM_GLYPHS = 6,
    parameter int ORIGIN_X   = 16,
    parameter int ORIGIN_Y   = 8
) (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          px_valid,
    input  coord_t                        px_x,
    input  coord_t                        px_y,
    input  pixel_t                        pixel_in,
    output logic [$clog2(NUM_GLYPHS)-1:0] rd_slot,
    input  glyph_e                        rd_glyph,
    output logic                          pix_valid,
    output pixel_t                        pixel_out
);

    localparam int FONT_SH = $clog2(FONT_W);
    localparam int SLOT_W  = $clog2(NUM_GLYPHS);

    // window bounds, hi ends exclusive
    localparam coord_t X_LO = coord_t'(ORIGIN_X);
    localparam coord_t X_HI = coord_t'(ORIGIN_X + NUM_GLYPHS * FONT_W);
    localparam coord_t Y_LO = coord_t'(ORIGIN_Y);
    localparam coord_t Y_HI = coord_t'(ORIGIN_Y + FONT_W);

    coord_t             dx;
    coord_t             dy;
    logic               in_window;
    logic [FONT_SH-1:0] col;
    logic [FONT_SH-1:0] font_row;
    logic [FONT_W-1:0]  font_bits;
    logic               ink;

    assign dx = px_x - X_LO;
    assign dy = px_y - Y_LO;

    assign in_window = (px_x >= X_LO) && (px_x < X_HI) &&
                       (px_y >= Y_LO) && (px_y < Y_HI);

    assign rd_slot  = in_window ? SLOT_W'(dx >> FONT_SH) : '0;  // park on slot 0 outside
    assign col      = dx[FONT_SH-1:0];
    assign font_row = FONT_SH'(FONT_W - 1) - dy[FONT_SH-1:0];  // row 7 is the top line

    assign font_bits = FONT_ROWS[rd_glyph][font_row];
    assign ink       = font_bits[FONT_SH'(FONT_W - 1) - col];  // msb is leftmost

    always_ff @(posedge clk) begin
        if (rst) begin
            pix_valid <= 1'b0;
        end else begin
            pix_valid <= px_valid;
        end
    end

    // one stage, no back-pressure
    always_ff @(posedge clk) begin
        if (!in_window) begin
            pixel_out <= pixel_in;
        end else if (ink) begin
            pixel_out <= FG_PIXEL;
        end else begin
            pixel_out <= BG_PIXEL;
        end
    end

endmodule

// File: logic/debug_overlay.sv
module debug_overlay import overlay_cfg_pkg::*, glyph_pkg::*; #(
    parameter int VALUE_W  = 16,
    parameter int ORIGIN_X = 16,
    parameter int ORIGIN_Y = 8
) (
    input  logic               clk,
    input  logic               rst,
    input  logic [VALUE_W-1:0] value,
    input  logic               value_strobe,
    output logic               busy,
    input  logic               frame_start,
    input  logic               px_valid,
    input  coord_t             px_x,
    input  coord_t             px_y,
    input  pixel_t             pixel_in,
    output logic               pix_valid,
    output pixel_t             pixel_out
);

    // decimal digits of 2**(VALUE_W-1), the largest magnitude
    // 30103 / 100000 stands in for log10(2)
    localparam int NUM_DIGITS = ((VALUE_W - 1) * 30103) / 100000 + 1;
    localparam int NUM_GLYPHS = NUM_DIGITS + 1;  // plus sign
    localparam int SLOT_W     = $clog2(NUM_GLYPHS);

    logic [SLOT_W-1:0] rd_slot;
    glyph_e            rd_glyph;

    glyph_wr_if #(.NUM_GLYPHS(NUM_GLYPHS)) glyph_wr ();

    bcd_converter #(
        .VALUE_W    (VALUE_W),
        .NUM_DIGITS (NUM_DIGITS),
        .NUM_GLYPHS (NUM_GLYPHS)
    ) bcd_converter_inst (
        .clk          (clk),
        .rst          (rst),
        .value        (value),
        .value_strobe (value_strobe),
        .busy         (busy),
        .wr           (glyph_wr.src)
    );

    glyph_buffer #(
        .NUM_GLYPHS (NUM_GLYPHS)
    ) glyph_buffer_inst (
        .clk         (clk),
        .rst         (rst),
        .wr          (glyph_wr.dst),
        .frame_start (frame_start),
        .rd_slot     (rd_slot),
        .rd_glyph    (rd_glyph)
    );

    glyph_renderer #(
        .NUM_GLYPHS (NUM_GLYPHS),
        .ORIGIN_X   (ORIGIN_X),
        .ORIGIN_Y   (ORIGIN_Y)
    ) glyph_renderer_inst (
        .clk       (clk),
        .rst       (rst),
        .px_valid  (px_valid),
        .px_x      (px_x),
        .px_y      (px_y),
        .pixel_in  (pixel_in),
        .rd_slot   (rd_slot),
        .rd_glyph  (rd_glyph),
        .pix_valid (pix_valid),
        .pixel_out (pixel_out)
    );

endmodule

// File: dv/tb_debug_overlay.sv
module tb_debug_overlay import overlay_cfg_pkg::*, glyph_pkg::*;;

    localparam int VALUE_W      = 16;
    localparam int NUM_DIGITS   = 5;
    localparam int NUM_GLYPHS   = NUM_DIGITS + 1;
    localparam int ORIGIN_X     = 16;
    localparam int ORIGIN_Y     = 8;
    localparam int WIN_W        = NUM_GLYPHS * FONT_W;
    localparam int BUSY_TIMEOUT = 100;  // well above VALUE_W + NUM_GLYPHS
    localparam int unsigned SEED = 32'h39d07269;

    logic               clk;
    logic               rst;
    logic [VALUE_W-1:0] value;
    logic               value_strobe;
    logic               busy;
    logic               frame_start;
    logic               px_valid;
    coord_t             px_x;
    coord_t             px_y;
    pixel_t             pixel_in;
    logic               pix_valid;
    pixel_t             pixel_out;

    // stimulus table with one entry per value
    logic [VALUE_W-1:0] stim_value [$];
    string              stim_text  [$];  // sign glyph then zero-padded digits
    bit                 stim_dup   [$];  // second strobe while busy
    bit                 stim_early [$];  // scan before frame_start

    int shown_glyphs [NUM_GLYPHS];  // what the window should show now
    int next_glyphs  [NUM_GLYPHS];  // what the pending commit holds

    debug_overlay #(
        .VALUE_W  (VALUE_W),
        .ORIGIN_X (ORIGIN_X),
        .ORIGIN_Y (ORIGIN_Y)
    ) debug_overlay_inst (
        .clk          (clk),
        .rst          (rst),
        .value        (value),
        .value_strobe (value_strobe),
        .busy         (busy),
        .frame_start  (frame_start),
        .px_valid     (px_valid),
        .px_x         (px_x),
        .px_y         (px_y),
        .pixel_in     (pixel_in),
        .pix_valid    (pix_valid),
        .pixel_out    (pixel_out)
    );

    always #2 clk = ~clk;

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("error: %s actual 0x%0h expected 0x%0h", name, actual, expected);
            $display("** FAIL **");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    task automatic report_timeout(input string what);
        $display("timeout: %s", what);
        $display("** FAIL **");
        $fatal(1, "wait expired");
    endtask

    task automatic add_entry(input logic [VALUE_W-1:0] v, input string text,
                             input bit dup, input bit early);
        stim_value.push_back(v);
        stim_text.push_back(text);
        stim_dup.push_back(dup);
        stim_early.push_back(early);
    endtask

    // sign glyph then the magnitude as zero-padded decimal
    function automatic string value_text(input int v);
        bit neg;
        int mag;
        neg = (v < 0);
        mag = neg ? -v : v;
        return $sformatf("%c%05d", neg ? 8'h2d : 8'h20, mag);
    endfunction

    function automatic int glyph_of_char(input byte c);
        if (c == "-") begin
            return int'(GLYPH_MINUS);
        end else if (c == " ") begin
            return int'(GLYPH_BLANK);
        end
        return int'(c) - int'("0");
    endfunction

    task automatic load_glyphs(input string text);
        for (int i = 0; i < NUM_GLYPHS; i++) begin
            next_glyphs[i] = glyph_of_char(text[i]);
        end
    endtask

    function automatic pixel_t expected_pixel(input int x, input int y, input pixel_t in_px);
        int         slot;
        int         col;
        int         row;
        logic [7:0] bits;
        if (x < ORIGIN_X || x >= ORIGIN_X + WIN_W || y < ORIGIN_Y || y >= ORIGIN_Y + FONT_W) begin
            return in_px;  // outside the window
        end
        slot = (x - ORIGIN_X) / FONT_W;
        col  = (x - ORIGIN_X) % FONT_W;
        row  = FONT_W - 1 - (y - ORIGIN_Y);  // top line is row 7
        bits = FONT_ROWS[shown_glyphs[slot]][row];
        return bits[FONT_W - 1 - col] ? FG_PIXEL : BG_PIXEL;
    endfunction

    // strobe a value in and count busy cycles with an optional second strobe
    task automatic run_conversion(input logic [VALUE_W-1:0] v, input bit dup);
        int busy_cycles;
        int guard;
        busy_cycles  = 0;
        guard        = 0;
        value        = v;
        value_strobe = 1'b1;
        @(negedge clk);
        value_strobe = 1'b0;
        while (busy) begin
            busy_cycles++;
            guard++;
            if (guard > BUSY_TIMEOUT) begin
                report_timeout("busy stayed high after a value strobe");
            end
            if (dup && busy_cycles == 3) begin
                value        = ~v;  // must not reach the display
                value_strobe = 1'b1;
            end else begin
                value_strobe = 1'b0;
            end
            @(negedge clk);
        end
        value_strobe = 1'b0;
        check_value("busy cycles", 32'(busy_cycles), 32'(VALUE_W + NUM_GLYPHS));
    endtask

    // drive one stream beat and check it one cycle later
    task automatic step_pixel(input bit valid, input int x, input int y);
        pixel_t in_px;
        pixel_t expect_px;
        in_px     = pixel_t'($urandom);
        expect_px = expected_pixel(x, y, in_px);
        px_valid  = valid;
        px_x      = coord_t'(x);
        px_y      = coord_t'(y);
        pixel_in  = in_px;
        @(negedge clk);
        check_value("pix_valid", 32'(pix_valid), 32'(valid));
        if (valid) begin
            check_value($sformatf("pixel_out at x=%0d y=%0d", x, y),
                        32'(pixel_out), 32'(expect_px));
        end
    endtask

    // window plus a one pixel border with random idle gaps
    task automatic scan_window();
        for (int y = ORIGIN_Y - 1; y <= ORIGIN_Y + FONT_W; y++) begin
            for (int x = ORIGIN_X - 1; x <= ORIGIN_X + WIN_W; x++) begin
                if (($urandom & 32'd3) == 32'd0) begin
                    step_pixel(1'b0, 0, 0);
                end
                step_pixel(1'b1, x, y);
            end
        end
        step_pixel(1'b0, 0, 0);
    endtask

    initial begin
        logic [VALUE_W-1:0] rv;
        void'($urandom(SEED));
        clk          = 1'b0;
        rst          = 1'b1;
        value        = '0;
        value_strobe = 1'b0;
        frame_start  = 1'b0;
        px_valid     = 1'b0;
        px_x         = '0;
        px_y         = '0;
        pixel_in     = '0;
        for (int i = 0; i < NUM_GLYPHS; i++) begin
            shown_glyphs[i] = int'(GLYPH_BLANK);  // both banks start blank
        end

        add_entry(16'd0,      " 00000", 1'b0, 1'b1);
        add_entry(16'd1234,   " 01234", 1'b1, 1'b0);
        add_entry(-16'sd1,    "-00001", 1'b0, 1'b1);
        add_entry(16'd32767,  " 32767", 1'b0, 1'b0);
        add_entry(16'h8000,   "-32768", 1'b1, 1'b1);
        add_entry(16'd9,      " 00009", 1'b1, 1'b0);
        add_entry(-16'sd700,  "-00700", 1'b0, 1'b1);
        for (int i = 0; i < 4; i++) begin
            rv = VALUE_W'($urandom);
            add_entry(rv, value_text(int'($signed(rv))), (i % 2) == 1, i >= 2);
        end

        repeat (5) @(negedge clk);
        rst = 1'b0;
        check_value("busy", 32'(busy), 32'd0);
        check_value("pix_valid", 32'(pix_valid), 32'd0);

        for (int e = 0; e < stim_value.size(); e++) begin
            load_glyphs(stim_text[e]);
            run_conversion(stim_value[e], stim_dup[e]);
            if (stim_early[e]) begin
                scan_window();  // old value until the frame edge
            end
            frame_start = 1'b1;
            @(negedge clk);
            frame_start  = 1'b0;
            shown_glyphs = next_glyphs;
            scan_window();
        end

        $display("** PASS **");
        $finish;
    end

endmodule

// File: flist.f
+incdir+include
logic/overlay_cfg_pkg.sv
logic/glyph_pkg.sv
logic/glyph_wr_if.sv
logic/bcd_converter.sv
logic/glyph_buffer.sv
logic/glyph_renderer.sv
logic/debug_overlay.sv
dv/tb_debug_overlay.sv

// File: run_sim.sh
#!/bin/sh
# builds the debug overlay testbench with Verilator and runs it
set -e
cd "$(dirname "$0")"

verilator --binary --timing -j 0 --top-module tb_debug_overlay -f flist.f

# the simulator exits non-zero on $fatal, so its status is not used directly
sim_out=$(./obj_dir/Vtb_debug_overlay 2>&1) || true
printf '%s\n' "$sim_out"

if printf '%s\n' "$sim_out" | grep -q -F '** PASS **'; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi
